//--- common/lsqPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes and types for the load/store queue control
// queue depth must stay a power of two, pointers wrap by bit width
// lane counts assume at most 3 per cycle (2-bit laneCntT)
// no overflow check anywhere, dispatch must respect the counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsqPkg;

  // queue depth, same for load and store queue
  localparam int LsqSize = 16;

  // index width for LsqSize entries
  localparam int LsqSizeLog = 4;

  // dispatch lanes per cycle
  localparam int DispatchWidth = 2;

  // retire lanes per cycle
  localparam int CommitWidth = 2;

  // queue index, wraps naturally
  typedef logic [LsqSizeLog-1:0] lsqIdxT;

  // occupancy, one extra bit so a full queue reads 16
  typedef logic [LsqSizeLog:0] lsqCntT;

  // per-cycle instruction count, 0 to 2
  typedef logic [1:0] laneCntT;

  // one bit per queue entry
  typedef logic [LsqSize-1:0] lsqVecT;

endpackage

//--- dispatch/lsqDispatchDecode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch decode for the LSQ, purely combinational
// at most one of isLoad_i / isStore_i per lane
// IDs are computed every cycle, only lsqID_o and counts honor
// dispatchReady_i
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsqDispatchDecode (
  input  logic                               dispatchReady_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isLoad_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isStore_i,
  input  lsqPkg::lsqIdxT                     ldqTail_i,
  input  lsqPkg::lsqIdxT                     stqTail_i,
  output lsqPkg::lsqIdxT                     ldqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::lsqIdxT                     stqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::lsqIdxT                     lsqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::laneCntT                    newLdCount_o,
  output lsqPkg::laneCntT                    newStCount_o
);

  // totals over all lanes, before the ready qualifier
  lsqPkg::laneCntT ldTotal;
  lsqPkg::laneCntT stTotal;

  // each lane takes the tail plus same-kind instructions in lower lanes
  always_comb
  begin
    lsqPkg::laneCntT ldSeen;
    lsqPkg::laneCntT stSeen;
    ldSeen = '0;
    stSeen = '0;
    for (int i = 0; i < lsqPkg::DispatchWidth; i++)
    begin
      ldqID_o[i] = ldqTail_i + lsqPkg::lsqIdxT'(ldSeen);
      stqID_o[i] = stqTail_i + lsqPkg::lsqIdxT'(stSeen);
      // running count for the next lane up
      ldSeen = ldSeen + lsqPkg::laneCntT'(isLoad_i[i]);
      stSeen = stSeen + lsqPkg::laneCntT'(isStore_i[i]);
    end
    ldTotal = ldSeen;
    stTotal = stSeen;
  end

  // unified ID that travels down the pipe with the instruction
  always_comb
  begin
    for (int i = 0; i < lsqPkg::DispatchWidth; i++)
    begin
      lsqID_o[i] = '0;
      if (dispatchReady_i)
      begin
        if (isLoad_i[i])
        begin
          lsqID_o[i] = ldqID_o[i];
        end
        else if (isStore_i[i])
        begin
          lsqID_o[i] = stqID_o[i];
        end
      end
    end
  end

  // no allocation unless the dispatch stage fires
  assign newLdCount_o = dispatchReady_i ? ldTotal : '0;
  assign newStCount_o = dispatchReady_i ? stTotal : '0;

endmodule

//--- ldq/loadQueueCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load queue pointers and occupancy
// retiring loads must occupy the lowest commit lanes
// recovery empties the whole queue and wins over dispatch and retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module loadQueueCtrl (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               recoverFlag_i,
  input  logic                               dispatchReady_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isLoad_i,
  input  lsqPkg::lsqIdxT                     ldqID_i [0:lsqPkg::DispatchWidth-1],
  input  lsqPkg::laneCntT                    newLdCount_i,
  input  logic [lsqPkg::CommitWidth-1:0]     commitLoad_i,
  output lsqPkg::lsqIdxT                     ldqHead_o,
  output lsqPkg::lsqIdxT                     ldqTail_o,
  output lsqPkg::lsqCntT                     ldqCount_o,
  output lsqPkg::laneCntT                    commitLdCount_o,
  output lsqPkg::lsqIdxT                     commitLdIndex_o [0:lsqPkg::CommitWidth-1]
);

  lsqPkg::lsqIdxT ldqHeadNext;
  lsqPkg::lsqIdxT ldqTailNext;
  lsqPkg::lsqCntT ldqCountNext;

  // count retiring loads, retire lane i sits at head + i
  always_comb
  begin
    lsqPkg::laneCntT retired;
    retired = '0;
    for (int i = 0; i < lsqPkg::CommitWidth; i++)
    begin
      retired = retired + lsqPkg::laneCntT'(commitLoad_i[i]);
      commitLdIndex_o[i] = ldqHead_o + lsqPkg::lsqIdxT'(i);
    end
    commitLdCount_o = retired;
  end

  // next pointers, wrap comes free from the index width
  always_comb
  begin
    ldqHeadNext  = ldqHead_o + lsqPkg::lsqIdxT'(commitLdCount_o);
    ldqTailNext  = ldqTail_o + lsqPkg::lsqIdxT'(newLdCount_i);
    ldqCountNext = ldqCount_o + lsqPkg::lsqCntT'(newLdCount_i)
                   - lsqPkg::lsqCntT'(commitLdCount_o);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ldqHead_o  <= '0;
      ldqTail_o  <= '0;
      ldqCount_o <= '0;
    end
    else if (recoverFlag_i)
    begin
      // all loads in flight are squashed
      ldqHead_o  <= '0;
      ldqTail_o  <= '0;
      ldqCount_o <= '0;
    end
    else
    begin
      ldqHead_o  <= ldqHeadNext;
      ldqTail_o  <= ldqTailNext;
      ldqCount_o <= ldqCountNext;
    end
  end

endmodule

//--- stq/storeQueueCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue pointers, occupancy and valid bits
// three pointers: head (next to drain), commit pointer (first
// uncommitted store) and tail (next free slot)
// recovery keeps committed stores, drops the rest, tail -> commit ptr
// head and commit pointer hold during recovery
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module storeQueueCtrl (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               recoverFlag_i,
  input  logic                               dispatchReady_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isStore_i,
  input  lsqPkg::lsqIdxT                     stqID_i [0:lsqPkg::DispatchWidth-1],
  input  lsqPkg::laneCntT                    newStCount_i,
  input  logic                               commitSt_i,
  input  lsqPkg::laneCntT                    commitStCount_i,
  input  lsqPkg::lsqVecT                     stqCommitVec_i,
  output lsqPkg::lsqIdxT                     stqHead_o,
  output lsqPkg::lsqIdxT                     stqTail_o,
  output lsqPkg::lsqIdxT                     stqCommitPtr_o,
  output lsqPkg::lsqCntT                     stqCount_o,
  output logic                               stqHeadValid_o
);

  lsqPkg::lsqVecT stqValid;
  lsqPkg::lsqVecT stqValidNext;
  lsqPkg::lsqIdxT stqHeadNext;
  lsqPkg::lsqIdxT stqTailNext;
  lsqPkg::lsqIdxT stqCommitPtrNext;
  lsqPkg::lsqCntT stqCountNext;

  // state after a flush of uncommitted stores
  lsqPkg::lsqVecT stqValidRecover;
  lsqPkg::lsqCntT stqCountRecover;

  // drain side looks at the head entry
  assign stqHeadValid_o = stqValid[stqHead_o];

  // normal operation
  always_comb
  begin
    // one store leaves per drain strobe
    stqHeadNext      = stqHead_o + lsqPkg::lsqIdxT'(commitSt_i);
    stqCommitPtrNext = stqCommitPtr_o + lsqPkg::lsqIdxT'(commitStCount_i);
    stqTailNext      = stqTail_o + lsqPkg::lsqIdxT'(newStCount_i);
    stqCountNext     = stqCount_o + lsqPkg::lsqCntT'(newStCount_i)
                       - lsqPkg::lsqCntT'(commitSt_i);

    stqValidNext = stqValid;
    // written to the cache, entry is free
    if (commitSt_i)
    begin
      stqValidNext[stqHead_o] = 1'b0;
    end
    // new stores from dispatch
    for (int i = 0; i < lsqPkg::DispatchWidth; i++)
    begin
      if (dispatchReady_i && isStore_i[i])
      begin
        stqValidNext[stqID_i[i]] = 1'b1;
      end
    end
  end

  // recovery flush
  // valid but not committed entries are dropped and uncounted
  always_comb
  begin
    lsqPkg::lsqCntT dropped;
    dropped = '0;
    for (int i = 0; i < lsqPkg::LsqSize; i++)
    begin
      dropped = dropped + lsqPkg::lsqCntT'(stqValid[i] & ~stqCommitVec_i[i]);
    end
    stqValidRecover = stqValid & stqCommitVec_i;
    stqCountRecover = stqCount_o - dropped;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      stqHead_o      <= '0;
      stqTail_o      <= '0;
      stqCommitPtr_o <= '0;
      stqCount_o     <= '0;
      stqValid       <= '0;
    end
    else if (recoverFlag_i)
    begin
      // head and commit pointer stay, committed stores keep draining
      stqTail_o  <= stqCommitPtr_o;
      stqCount_o <= stqCountRecover;
      stqValid   <= stqValidRecover;
    end
    else
    begin
      stqHead_o      <= stqHeadNext;
      stqTail_o      <= stqTailNext;
      stqCommitPtr_o <= stqCommitPtrNext;
      stqCount_o     <= stqCountNext;
      stqValid       <= stqValidNext;
    end
  end

endmodule

//--- stq/storeDrainCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// committed-store marks and the data cache write strobe
// one store per cycle from the head, stallStCommit_i holds it off
// retiring stores must occupy the lowest commit lanes
// marks set at an edge are seen by the drain one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module storeDrainCtrl (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               recoverFlag_i,
  input  logic [lsqPkg::CommitWidth-1:0]     commitStore_i,
  input  logic                               stallStCommit_i,
  input  lsqPkg::lsqIdxT                     stqHead_i,
  input  lsqPkg::lsqIdxT                     stqCommitPtr_i,
  input  logic                               stqHeadValid_i,
  output logic                               commitSt_o,
  output lsqPkg::laneCntT                    commitStCount_o,
  output lsqPkg::lsqVecT                     stqCommitVec_o
);

  lsqPkg::lsqVecT commitVecNext;

  // number of stores retiring this cycle
  always_comb
  begin
    lsqPkg::laneCntT retired;
    retired = '0;
    for (int i = 0; i < lsqPkg::CommitWidth; i++)
    begin
      retired = retired + lsqPkg::laneCntT'(commitStore_i[i]);
    end
    commitStCount_o = retired;
  end

  // write the head store when it is live, retired and cache is free
  assign commitSt_o = stqHeadValid_i & stqCommitVec_o[stqHead_i] & ~stallStCommit_i;

  always_comb
  begin
    lsqPkg::lsqIdxT markIdx;
    commitVecNext = stqCommitVec_o;
    // drained store no longer waits
    if (commitSt_o)
    begin
      commitVecNext[stqHead_i] = 1'b0;
    end
    // retiring stores are consecutive from the commit pointer
    for (int i = 0; i < lsqPkg::CommitWidth; i++)
    begin
      markIdx = stqCommitPtr_i + lsqPkg::lsqIdxT'(i);
      if (commitStore_i[i])
      begin
        commitVecNext[markIdx] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      stqCommitVec_o <= '0;
    end
    // frozen while recovering
    else if (!recoverFlag_i)
    begin
      stqCommitVec_o <= commitVecNext;
    end
  end

endmodule

//--- rtl/lsuControl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store queue control top
// fixed 16-entry load and store queues, 2 dispatch and 2 retire lanes
// no overflow protection, dispatch must watch ldqCount_o / stqCount_o
// commitSt_o is a single-cycle write strobe to the data cache
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsuControl (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               recoverFlag_i,
  input  logic                               dispatchReady_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isLoad_i,
  input  logic [lsqPkg::DispatchWidth-1:0]   isStore_i,
  input  logic [lsqPkg::CommitWidth-1:0]     commitLoad_i,
  input  logic [lsqPkg::CommitWidth-1:0]     commitStore_i,
  input  logic                               stallStCommit_i,
  output lsqPkg::lsqIdxT                     lsqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::lsqIdxT                     ldqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::lsqIdxT                     stqID_o [0:lsqPkg::DispatchWidth-1],
  output lsqPkg::lsqCntT                     ldqCount_o,
  output lsqPkg::lsqCntT                     stqCount_o,
  output lsqPkg::lsqIdxT                     ldqHead_o,
  output lsqPkg::lsqIdxT                     ldqTail_o,
  output lsqPkg::lsqIdxT                     stqHead_o,
  output lsqPkg::lsqIdxT                     stqTail_o,
  output lsqPkg::laneCntT                    commitLdCount_o,
  output lsqPkg::lsqIdxT                     commitLdIndex_o [0:lsqPkg::CommitWidth-1],
  output logic                               commitSt_o
);

  // decode to both queues
  lsqPkg::laneCntT newLdCount;
  lsqPkg::laneCntT newStCount;

  // store queue <-> drain
  lsqPkg::lsqIdxT  stqCommitPtr;
  logic            stqHeadValid;
  lsqPkg::laneCntT commitStCount;
  lsqPkg::lsqVecT  stqCommitVec;

  // IDs from the current tails
  lsqDispatchDecode decode (
    .dispatchReady_i (dispatchReady_i),
    .isLoad_i        (isLoad_i),
    .isStore_i       (isStore_i),
    .ldqTail_i       (ldqTail_o),
    .stqTail_i       (stqTail_o),
    .ldqID_o         (ldqID_o),
    .stqID_o         (stqID_o),
    .lsqID_o         (lsqID_o),
    .newLdCount_o    (newLdCount),
    .newStCount_o    (newStCount)
  );

  loadQueueCtrl loadQ (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag_i),
    .dispatchReady_i (dispatchReady_i),
    .isLoad_i        (isLoad_i),
    .ldqID_i         (ldqID_o),
    .newLdCount_i    (newLdCount),
    .commitLoad_i    (commitLoad_i),
    .ldqHead_o       (ldqHead_o),
    .ldqTail_o       (ldqTail_o),
    .ldqCount_o      (ldqCount_o),
    .commitLdCount_o (commitLdCount_o),
    .commitLdIndex_o (commitLdIndex_o)
  );

  storeQueueCtrl storeQ (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag_i),
    .dispatchReady_i (dispatchReady_i),
    .isStore_i       (isStore_i),
    .stqID_i         (stqID_o),
    .newStCount_i    (newStCount),
    .commitSt_i      (commitSt_o),
    .commitStCount_i (commitStCount),
    .stqCommitVec_i  (stqCommitVec),
    .stqHead_o       (stqHead_o),
    .stqTail_o       (stqTail_o),
    .stqCommitPtr_o  (stqCommitPtr),
    .stqCount_o      (stqCount_o),
    .stqHeadValid_o  (stqHeadValid)
  );

  // committed marks and cache write strobe
  storeDrainCtrl drain (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag_i),
    .commitStore_i   (commitStore_i),
    .stallStCommit_i (stallStCommit_i),
    .stqHead_i       (stqHead_o),
    .stqCommitPtr_i  (stqCommitPtr),
    .stqHeadValid_i  (stqHeadValid),
    .commitSt_o      (commitSt_o),
    .commitStCount_o (commitStCount),
    .stqCommitVec_o  (stqCommitVec)
  );

endmodule

//--- tb/lsqRefModel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral load/store queue model for the testbench
// queues kept as lists of indices, oldest entry first
// committed stores always sit at the front of the store list
// stimulus must respect free space and live counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsqRefModel (
  input  logic       clk,
  input  logic       reset,
  input  logic       recoverFlag_i,
  input  logic       dispatchReady_i,
  input  logic [1:0] isLoad_i,
  input  logic [1:0] isStore_i,
  input  logic [1:0] commitLoad_i,
  input  logic [1:0] commitStore_i,
  input  logic       stallStCommit_i,
  output int         ldHead_o,
  output int         ldTail_o,
  output int         ldCount_o,
  output int         stHead_o,
  output int         stTail_o,
  output int         stCommitPtr_o,
  output int         stCount_o,
  output int         stCommitted_o,
  output int         stFront_o,
  output logic       drainExp_o
);

  int ldList[$];
  int stList[$];

  // oldest store retired and not stalled, marks from last edge only
  assign drainExp_o = (stCommitted_o > 0) && !stallStCommit_i;

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ldList.delete();
      stList.delete();
      ldHead_o      = 0;
      ldTail_o      = 0;
      stHead_o      = 0;
      stTail_o      = 0;
      stCommitPtr_o = 0;
      stCommitted_o = 0;
    end
    else if (recoverFlag_i)
    begin
      // loads squashed, uncommitted stores dropped from the young end
      ldList.delete();
      ldHead_o = 0;
      ldTail_o = 0;
      while (stList.size() > stCommitted_o)
      begin
        void'(stList.pop_back());
      end
      stTail_o = stCommitPtr_o;
    end
    else
    begin
      // drain decision uses marks from before this edge
      if (drainExp_o)
      begin
        void'(stList.pop_front());
        stCommitted_o = stCommitted_o - 1;
        stHead_o      = (stHead_o + 1) % 16;
      end
      for (int i = 0; i < 2; i++)
      begin
        if (commitLoad_i[i])
        begin
          void'(ldList.pop_front());
          ldHead_o = (ldHead_o + 1) % 16;
        end
        if (commitStore_i[i])
        begin
          stCommitted_o = stCommitted_o + 1;
          stCommitPtr_o = (stCommitPtr_o + 1) % 16;
        end
      end
      // new entries in lane order
      for (int i = 0; i < 2; i++)
      begin
        if (dispatchReady_i && isLoad_i[i])
        begin
          ldList.push_back(ldTail_o);
          ldTail_o = (ldTail_o + 1) % 16;
        end
        else if (dispatchReady_i && isStore_i[i])
        begin
          stList.push_back(stTail_o);
          stTail_o = (stTail_o + 1) % 16;
        end
      end
    end
    ldCount_o = ldList.size();
    stCount_o = stList.size();
    stFront_o = (stList.size() > 0) ? stList[0] : 0;
  end

endmodule

//--- tb/lsuControlTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random testbench for the load/store queue control
// inputs change on the falling edge, state checked one edge later
// combinational outputs checked 1 ns after inputs settle
// random bits from a 32-bit Fibonacci LFSR, taps 32 22 2 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lsuControlTb;

  localparam int RandomCycles  = 2000;
  localparam int ResetCycles   = 10;
  localparam int TimeoutCycles = RandomCycles + RandomCycles / 4;

  logic clk;
  logic reset;
  logic recoverFlag;
  logic dispatchReady;
  logic stallStCommit;
  logic [1:0] isLoad;
  logic [1:0] isStore;
  logic [1:0] commitLoad;
  logic [1:0] commitStore;

  lsqPkg::lsqIdxT  lsqID [0:lsqPkg::DispatchWidth-1];
  lsqPkg::lsqIdxT  ldqID [0:lsqPkg::DispatchWidth-1];
  lsqPkg::lsqIdxT  stqID [0:lsqPkg::DispatchWidth-1];
  lsqPkg::lsqIdxT  commitLdIndex [0:lsqPkg::CommitWidth-1];
  lsqPkg::lsqCntT  ldqCount;
  lsqPkg::lsqCntT  stqCount;
  lsqPkg::lsqIdxT  ldqHead;
  lsqPkg::lsqIdxT  ldqTail;
  lsqPkg::lsqIdxT  stqHead;
  lsqPkg::lsqIdxT  stqTail;
  lsqPkg::laneCntT commitLdCount;
  logic            commitSt;

  // model view
  int   mLdHead;
  int   mLdTail;
  int   mLdCount;
  int   mStHead;
  int   mStTail;
  int   mStCommitPtr;
  int   mStCount;
  int   mStCommitted;
  int   mStFront;
  logic mDrainExp;

  logic [31:0] lfsr;
  int errors;
  int checks;
  int cycles;
  int stallLeft;
  int prevStqHead;

  lsuControl dut (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag),
    .dispatchReady_i (dispatchReady),
    .isLoad_i        (isLoad),
    .isStore_i       (isStore),
    .commitLoad_i    (commitLoad),
    .commitStore_i   (commitStore),
    .stallStCommit_i (stallStCommit),
    .lsqID_o         (lsqID),
    .ldqID_o         (ldqID),
    .stqID_o         (stqID),
    .ldqCount_o      (ldqCount),
    .stqCount_o      (stqCount),
    .ldqHead_o       (ldqHead),
    .ldqTail_o       (ldqTail),
    .stqHead_o       (stqHead),
    .stqTail_o       (stqTail),
    .commitLdCount_o (commitLdCount),
    .commitLdIndex_o (commitLdIndex),
    .commitSt_o      (commitSt)
  );

  lsqRefModel model (
    .clk             (clk),
    .reset           (reset),
    .recoverFlag_i   (recoverFlag),
    .dispatchReady_i (dispatchReady),
    .isLoad_i        (isLoad),
    .isStore_i       (isStore),
    .commitLoad_i    (commitLoad),
    .commitStore_i   (commitStore),
    .stallStCommit_i (stallStCommit),
    .ldHead_o        (mLdHead),
    .ldTail_o        (mLdTail),
    .ldCount_o       (mLdCount),
    .stHead_o        (mStHead),
    .stTail_o        (mStTail),
    .stCommitPtr_o   (mStCommitPtr),
    .stCount_o       (mStCount),
    .stCommitted_o   (mStCommitted),
    .stFront_o       (mStFront),
    .drainExp_o      (mDrainExp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  task automatic drawBits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr = lfsrStep(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic checkValue(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected)
    begin
      errors++;
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // registered state, after the last rising edge
  task automatic checkState();
    checkValue("ldqHead", mLdHead, int'(ldqHead));
    checkValue("ldqTail", mLdTail, int'(ldqTail));
    checkValue("ldqCount", mLdCount, int'(ldqCount));
    checkValue("stqHead", mStHead, int'(stqHead));
    checkValue("stqTail", mStTail, int'(stqTail));
    checkValue("stqCount", mStCount, int'(stqCount));
    // recoverFlag still holds the value of the edge just taken
    if (recoverFlag)
    begin
      checkValue("recover ldqCount", 0, int'(ldqCount));
      checkValue("recover ldqHead", 0, int'(ldqHead));
      checkValue("recover ldqTail", 0, int'(ldqTail));
      checkValue("recover stqTail", mStCommitPtr, int'(stqTail));
      checkValue("recover stqCount", mStCommitted, int'(stqCount));
    end
    checks++;
    if (stallStCommit && int'(stqHead) != prevStqHead)
    begin
      errors++;
      $display("store queue head moved from %0d to %0d while the cache was stalled",
               prevStqHead, int'(stqHead));
    end
    prevStqHead = int'(stqHead);
  endtask

  // next cycle inputs, kept inside free space and live counts
  task automatic driveRandom();
    int r;
    int n;
    int ldFree;
    int stFree;
    drawBits(5, r);
    recoverFlag = (r == 0);
    // stall comes in bursts of 1 to 16 cycles
    if (stallLeft > 0)
    begin
      stallLeft--;
    end
    else
    begin
      drawBits(4, r);
      if (r == 0)
      begin
        drawBits(4, r);
        stallLeft = r + 1;
      end
    end
    stallStCommit = (stallLeft > 0);
    drawBits(2, r);
    dispatchReady = (r != 0);
    ldFree  = lsqPkg::LsqSize - mLdCount;
    stFree  = lsqPkg::LsqSize - mStCount;
    isLoad  = '0;
    isStore = '0;
    for (int i = 0; i < lsqPkg::DispatchWidth; i++)
    begin
      drawBits(2, r);
      if ((r == 1 || r == 3) && ldFree > 0)
      begin
        isLoad[i] = 1'b1;
        ldFree--;
      end
      else if (r == 2 && stFree > 0)
      begin
        isStore[i] = 1'b1;
        stFree--;
      end
    end
    // retires fill the lowest lanes
    drawBits(2, r);
    n = (r % 3 > mLdCount) ? mLdCount : r % 3;
    commitLoad = 2'((1 << n) - 1);
    drawBits(2, r);
    n = (r % 3 > mStCount - mStCommitted) ? mStCount - mStCommitted : r % 3;
    commitStore = 2'((1 << n) - 1);
  endtask

  // same-cycle outputs from current pointers and inputs
  task automatic checkComb();
    int ldSeen;
    int stSeen;
    int expLd;
    int expSt;
    int expLsq;
    ldSeen = 0;
    stSeen = 0;
    for (int i = 0; i < lsqPkg::DispatchWidth; i++)
    begin
      expLd  = (mLdTail + ldSeen) % 16;
      expSt  = (mStTail + stSeen) % 16;
      expLsq = 0;
      if (dispatchReady && isLoad[i])
      begin
        expLsq = expLd;
      end
      else if (dispatchReady && isStore[i])
      begin
        expLsq = expSt;
      end
      checkValue($sformatf("ldqID[%0d]", i), expLd, int'(ldqID[i]));
      checkValue($sformatf("stqID[%0d]", i), expSt, int'(stqID[i]));
      checkValue($sformatf("lsqID[%0d]", i), expLsq, int'(lsqID[i]));
      ldSeen = ldSeen + int'(isLoad[i]);
      stSeen = stSeen + int'(isStore[i]);
    end
    checkValue("commitLdCount", int'(commitLoad[0]) + int'(commitLoad[1]),
               int'(commitLdCount));
    for (int i = 0; i < lsqPkg::CommitWidth; i++)
    begin
      checkValue($sformatf("commitLdIndex[%0d]", i), (mLdHead + i) % 16,
                 int'(commitLdIndex[i]));
    end
    checkValue("commitSt", int'(mDrainExp), int'(commitSt));
    // drained store must be the oldest one
    if (commitSt && mStCount > 0)
    begin
      checkValue("drain index", mStFront, int'(stqHead));
    end
  endtask

  initial
  begin
    reset         = 1'b1;
    recoverFlag   = 1'b0;
    dispatchReady = 1'b0;
    stallStCommit = 1'b0;
    isLoad        = '0;
    isStore       = '0;
    commitLoad    = '0;
    commitStore   = '0;
    lfsr          = 32'h5147_c3df;
    errors        = 0;
    checks        = 0;
    stallLeft     = 0;
    prevStqHead   = 0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int c = 0; c < RandomCycles; c++)
    begin
      @(negedge clk);
      checkState();
      driveRandom();
      #1;
      checkComb();
    end
    @(negedge clk);
    checkState();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // run limit
  initial
  begin
    cycles = 0;
    while (cycles < TimeoutCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
common/lsqPkg.sv
dispatch/lsqDispatchDecode.sv
ldq/loadQueueCtrl.sv
stq/storeQueueCtrl.sv
stq/storeDrainCtrl.sv
rtl/lsuControl.sv
tb/lsqRefModel.sv
tb/lsuControlTb.sv

//--- Makefile
# Verilator build for the load/store queue control testbench

TOP = lsuControlTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

# pass only if the testbench printed its pass message
run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
